// File: rtl/udp_rx_pkg.sv
// UDP receive slot shared definitions
// Stream word, header field types, payload FIFO sizing and the
// Ethernet II / IPv4 / UDP constants used by the receive path
package udp_rx_pkg;

    typedef struct packed {
        logic       last;   // End of frame
        logic [7:0] data;
    } stream_word_t;

    typedef logic [47:0] mac_addr_t;
    typedef logic [15:0] udp_port_t;

    ////////////////////////////////////////
    // Payload buffer
    ////////////////////////////////////////
    localparam int unsigned PAYLOAD_DEPTH      = 1024;
    localparam int unsigned PAYLOAD_ADDR_WIDTH = $clog2(PAYLOAD_DEPTH);

    ////////////////////////////////////////
    // Accepted header values
    ////////////////////////////////////////
    localparam logic [15:0] ETHERTYPE_IPV4   = 16'h0800;
    localparam logic [7:0]  IPV4_VERSION_IHL = 8'h45;   // IPv4, no options
    localparam logic [7:0]  IP_PROTOCOL_UDP  = 8'd17;
    localparam logic [15:0] UDP_HEADER_BYTES = 16'd8;

    // Byte offsets from the first destination MAC byte
    localparam logic [15:0] OFFSET_ETHERTYPE   = 16'd12;
    localparam logic [15:0] OFFSET_VERSION_IHL = 16'd14;
    localparam logic [15:0] OFFSET_PROTOCOL    = 16'd23;
    localparam logic [15:0] OFFSET_UDP_DEST    = 16'd36;
    localparam logic [15:0] OFFSET_UDP_LENGTH  = 16'd38;
    localparam logic [15:0] OFFSET_PAYLOAD     = 16'd42;

    ////////////////////////////////////////
    // Frame check sequence
    ////////////////////////////////////////
    localparam logic [31:0] CRC32_POLY    = 32'h04C11DB7;
    // Register after a good frame plus FCS, preset to ones, no inversion
    localparam logic [31:0] CRC32_RESIDUE = 32'hDEBB20E3;

endpackage

// File: rtl/frame_check_sequence_checker.sv
`timescale 1ns/100ps
// Frame check sequence checker
// Runs a reflected CRC-32 over every byte of a frame, FCS included,
// and flags whether the register holds the good-frame residue once the
// last byte has gone in. Presets itself again for the next frame.
module frame_check_sequence_checker
    import udp_rx_pkg::*;
(
    input  logic       clock,
    input  logic       rst_n,
    input  logic [7:0] crc_data,
    input  logic       crc_enable,
    input  logic       crc_last,
    output logic       fcs_ok
);

    logic [31:0] crc;
    logic [31:0] crc_updated;

    // One byte, LSB first
    function automatic logic [31:0] crc_byte(input logic [31:0] value,
                                             input logic [7:0] data);
        logic [31:0] poly;
        logic [31:0] result;
        for (int i = 0; i < 32; i++) begin
            poly[i] = CRC32_POLY[31 - i];   // Bit reversed polynomial
        end
        result = value;
        for (int b = 0; b < 8; b++) begin
            result = (result >> 1) ^ ((result[0] ^ data[b]) ? poly : 32'h0);
        end
        return result;
    endfunction

    assign crc_updated = crc_byte(crc, crc_data);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            crc    <= '1;
            fcs_ok <= 1'b0;
        end else if (crc_enable) begin
            if (crc_last) begin
                fcs_ok <= (crc_updated == CRC32_RESIDUE);
                crc    <= '1;   // Preset for next frame
            end else begin
                crc    <= crc_updated;
            end
        end
    end

endmodule

// File: rtl/ethernet_frame_parser.sv
`timescale 1ns/100ps
// Ethernet frame parser for the UDP receive slot
// Walks the Ethernet II, IPv4 and UDP headers by byte offset, filters on
// destination MAC, EtherType, version/IHL, protocol and UDP port, and
// writes the UDP payload to the payload FIFO. Every accepted byte also
// goes to the FCS checker. One cycle after the last byte a single good
// or bad verdict is issued.
module ethernet_frame_parser
    import udp_rx_pkg::*;
(
    input  logic         clock,
    input  logic         rst_n,
    input  stream_word_t receive_data,
    input  logic         receive_data_enable,
    input  mac_addr_t    mac_address,
    input  udp_port_t    udp_port,
    input  logic         fcs_ok,
    input  logic         slot_free,
    output logic         receive_data_ready,
    output logic [7:0]   crc_data,
    output logic         crc_enable,
    output logic         crc_last,
    output logic [7:0]   payload_data,
    output logic         payload_enable,
    output logic         good_packet,
    output logic         bad_packet
);

    logic        in_frame;
    logic        frame_end;         // Verdict cycle
    logic [15:0] byte_count;
    logic        reject;            // Sticky for the current frame
    logic        own_hit;
    logic        bcast_hit;
    logic [7:0]  length_hi;
    logic [15:0] payload_length;
    logic [15:0] payload_end;
    logic [15:0] length_next;

    logic        accept;
    logic        first_byte;
    logic [7:0]  mac_byte;
    logic        own_hit_next;
    logic        bcast_hit_next;
    logic        field_bad;
    logic        short_frame;

    ////////////////////////////////////////
    // Input side and checker feed
    ////////////////////////////////////////
    assign receive_data_ready = !in_frame && !frame_end && slot_free;
    assign accept             = receive_data_enable && (in_frame || receive_data_ready);
    assign first_byte         = (byte_count == 16'd0);

    assign crc_data   = receive_data.data;
    assign crc_enable = accept;
    assign crc_last   = receive_data.last;

    assign payload_end = OFFSET_PAYLOAD + payload_length;
    assign length_next = {length_hi, receive_data.data} - UDP_HEADER_BYTES;

    // Payload only, padding and FCS stay out
    assign payload_data   = receive_data.data;
    assign payload_enable = accept && !reject && (byte_count >= OFFSET_PAYLOAD) &&
                            (byte_count < payload_end);

    assign good_packet = frame_end && !reject && fcs_ok;
    assign bad_packet  = frame_end && (reject || !fcs_ok);

    ////////////////////////////////////////
    // Header field checks
    ////////////////////////////////////////
    always_comb begin
        mac_byte = 8'h00;
        for (int i = 0; i < 6; i++) begin
            if (byte_count[2:0] == 3'(i)) begin
                mac_byte = mac_address[47 - 8 * i -: 8];
            end
        end
        own_hit_next   = (first_byte || own_hit) && (receive_data.data == mac_byte);
        bcast_hit_next = (first_byte || bcast_hit) && (receive_data.data == 8'hff);

        case (byte_count)
            16'd5:                     field_bad = !own_hit_next && !bcast_hit_next;
            OFFSET_ETHERTYPE:          field_bad = receive_data.data != ETHERTYPE_IPV4[15:8];
            OFFSET_ETHERTYPE + 16'd1:  field_bad = receive_data.data != ETHERTYPE_IPV4[7:0];
            OFFSET_VERSION_IHL:        field_bad = receive_data.data != IPV4_VERSION_IHL;
            OFFSET_PROTOCOL:           field_bad = receive_data.data != IP_PROTOCOL_UDP;
            OFFSET_UDP_DEST:           field_bad = receive_data.data != udp_port[15:8];
            OFFSET_UDP_DEST + 16'd1:   field_bad = receive_data.data != udp_port[7:0];
            OFFSET_UDP_LENGTH + 16'd1: field_bad = length_next > 16'(PAYLOAD_DEPTH);
            default:                   field_bad = 1'b0;
        endcase

        // Last byte must sit at or after the final FCS byte
        short_frame = byte_count < payload_end + 16'd3;
    end

    ////////////////////////////////////////
    // Frame state
    ////////////////////////////////////////
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            in_frame       <= 1'b0;
            frame_end      <= 1'b0;
            byte_count     <= 16'd0;
            reject         <= 1'b0;
            own_hit        <= 1'b0;
            bcast_hit      <= 1'b0;
            payload_length <= 16'd0;
        end else begin
            frame_end <= accept && receive_data.last;
            if (accept) begin
                reject <= (reject && !first_byte) || field_bad ||
                          (receive_data.last && short_frame);
                if (byte_count < 16'd6) begin
                    own_hit   <= own_hit_next;
                    bcast_hit <= bcast_hit_next;
                end
                if (byte_count == OFFSET_UDP_LENGTH + 16'd1) begin
                    payload_length <= length_next;
                end
                if (receive_data.last) begin
                    in_frame       <= 1'b0;
                    byte_count     <= 16'd0;
                    payload_length <= 16'd0;
                end else begin
                    in_frame <= 1'b1;
                    if (byte_count != 16'hffff) begin   // Saturate on giant frames
                        byte_count <= byte_count + 16'd1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept && byte_count == OFFSET_UDP_LENGTH) begin
            length_hi <= receive_data.data;
        end
    end

endmodule

// File: rtl/payload_fifo.sv
`timescale 1ns/100ps
// Payload FIFO
// Synchronous byte FIFO holding one UDP payload. Read data is registered
// and valid the cycle after a read. Flush empties it in one cycle.
module payload_fifo
    import udp_rx_pkg::*;
(
    input  logic                        clock,
    input  logic                        rst_n,
    input  logic [7:0]                  write_data,
    input  logic                        write_enable,
    input  logic                        read_enable,
    input  logic                        flush,
    output logic [7:0]                  read_data,
    output logic                        read_data_valid,
    output logic                        empty,
    output logic [PAYLOAD_ADDR_WIDTH:0] count
);

    logic [7:0]                  memory [PAYLOAD_DEPTH];
    logic [PAYLOAD_ADDR_WIDTH:0] write_pointer;
    logic [PAYLOAD_ADDR_WIDTH:0] read_pointer;
    logic                        full;
    logic                        do_write;
    logic                        do_read;

    // Extra pointer bit tells full from empty
    assign count = write_pointer - read_pointer;
    assign empty = (count == '0);
    assign full  = count[PAYLOAD_ADDR_WIDTH];

    assign do_write = write_enable && !full && !flush;
    assign do_read  = read_enable && !empty && !flush;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            write_pointer   <= '0;
            read_pointer    <= '0;
            read_data_valid <= 1'b0;
        end else if (flush) begin
            write_pointer   <= '0;
            read_pointer    <= '0;
            read_data_valid <= 1'b0;
        end else begin
            if (do_write) begin
                write_pointer <= write_pointer + 1'b1;
            end
            if (do_read) begin
                read_pointer <= read_pointer + 1'b1;
            end
            read_data_valid <= do_read;
        end
    end

    ////////////////////////////////////////
    // Storage
    ////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (do_write) begin
            memory[write_pointer[PAYLOAD_ADDR_WIDTH-1:0]] <= write_data;
        end
        if (do_read) begin
            read_data <= memory[read_pointer[PAYLOAD_ADDR_WIDTH-1:0]];
        end
    end

endmodule

// File: rtl/udp_receive_handler.sv
`timescale 1ns/100ps
// UDP receive handler
// Acts on the parser verdict. A good frame is drained from the payload
// FIFO to the output stream while out_enable is high, with last on the
// final byte. A bad frame is flushed from the FIFO.
module udp_receive_handler
    import udp_rx_pkg::*;
(
    input  logic                        clock,
    input  logic                        rst_n,
    input  logic                        good_packet,
    input  logic                        bad_packet,
    input  logic                        out_enable,
    input  logic [7:0]                  fifo_read_data,
    input  logic                        fifo_read_data_valid,
    input  logic [PAYLOAD_ADDR_WIDTH:0] fifo_count,
    output logic                        fifo_read_enable,
    output logic                        fifo_flush,
    output logic                        slot_free,
    output stream_word_t                out_data,
    output logic                        out_valid
);

    typedef enum logic [1:0] {
        IDLE,
        DRAIN,
        FLUSH
    } state_t;

    state_t                      state;
    logic [PAYLOAD_ADDR_WIDTH:0] out_left;      // Bytes still to emit
    logic                        skid_valid;
    logic [7:0]                  skid_data;

    assign slot_free  = (state == IDLE) && (fifo_count == '0);
    assign fifo_flush = (state == FLUSH);

    // FIFO holds only this frame, so its count is the reads left
    assign fifo_read_enable = (state == DRAIN) && out_enable && (fifo_count != '0);

    // Skid word goes first; it never coincides with fresh read data
    assign out_valid     = (state == DRAIN) && out_enable && (skid_valid || fifo_read_data_valid);
    assign out_data.data = skid_valid ? skid_data : fifo_read_data;
    assign out_data.last = (out_left == 1);

    ////////////////////////////////////////
    // Control
    ////////////////////////////////////////
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state      <= IDLE;
            out_left   <= '0;
            skid_valid <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    out_left <= fifo_count;     // Frame length on the verdict
                    if (bad_packet) begin
                        state <= FLUSH;
                    end else if (good_packet && fifo_count != '0) begin
                        state <= DRAIN;
                    end
                end
                DRAIN: begin
                    if (out_valid) begin
                        out_left <= out_left - 1'b1;
                        if (out_left == 1) begin
                            state <= IDLE;
                        end
                    end
                end
                FLUSH:   state <= IDLE;
                default: state <= IDLE;
            endcase

            if (fifo_read_data_valid && !out_enable) begin
                skid_valid <= 1'b1;             // Held off by the sink
            end else if (out_enable) begin
                skid_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (fifo_read_data_valid && !out_enable) begin
            skid_data <= fifo_read_data;
        end
    end

endmodule

// File: rtl/virtual_port_udp_rx.sv
`timescale 1ns/100ps
// UDP virtual port, receive slot
// Parser and FCS checker qualify each incoming frame, the payload FIFO
// holds its UDP payload, and the receive handler pushes it out or drops it
module virtual_port_udp_rx
    import udp_rx_pkg::*;
(
    input  logic         clock,
    input  logic         rst_n,
    input  mac_addr_t    mac_address,
    input  udp_port_t    udp_port,
    input  stream_word_t receive_data,
    input  logic         receive_data_enable,
    input  logic         out_enable,
    output logic         receive_data_ready,
    output stream_word_t out_data,
    output logic         out_valid
);

    logic [7:0]                  crc_data;
    logic                        crc_enable;
    logic                        crc_last;
    logic                        fcs_ok;
    logic [7:0]                  payload_data;
    logic                        payload_enable;
    logic                        good_packet;
    logic                        bad_packet;
    logic                        slot_free;
    logic                        fifo_read_enable;
    logic                        fifo_flush;
    logic [7:0]                  fifo_read_data;
    logic                        fifo_read_data_valid;
    logic [PAYLOAD_ADDR_WIDTH:0] fifo_count;

    ethernet_frame_parser ethernet_frame_parser (
        .clock               (clock),
        .rst_n               (rst_n),
        .receive_data        (receive_data),
        .receive_data_enable (receive_data_enable),
        .mac_address         (mac_address),
        .udp_port            (udp_port),
        .fcs_ok              (fcs_ok),
        .slot_free           (slot_free),
        .receive_data_ready  (receive_data_ready),
        .crc_data            (crc_data),
        .crc_enable          (crc_enable),
        .crc_last            (crc_last),
        .payload_data        (payload_data),
        .payload_enable      (payload_enable),
        .good_packet         (good_packet),
        .bad_packet          (bad_packet)
    );

    frame_check_sequence_checker frame_check_sequence_checker (
        .clock      (clock),
        .rst_n      (rst_n),
        .crc_data   (crc_data),
        .crc_enable (crc_enable),
        .crc_last   (crc_last),
        .fcs_ok     (fcs_ok)
    );

    payload_fifo payload_fifo (
        .clock           (clock),
        .rst_n           (rst_n),
        .write_data      (payload_data),
        .write_enable    (payload_enable),
        .read_enable     (fifo_read_enable),
        .flush           (fifo_flush),
        .read_data       (fifo_read_data),
        .read_data_valid (fifo_read_data_valid),
        .empty           (),
        .count           (fifo_count)
    );

    udp_receive_handler udp_receive_handler (
        .clock                (clock),
        .rst_n                (rst_n),
        .good_packet          (good_packet),
        .bad_packet           (bad_packet),
        .out_enable           (out_enable),
        .fifo_read_data       (fifo_read_data),
        .fifo_read_data_valid (fifo_read_data_valid),
        .fifo_count           (fifo_count),
        .fifo_read_enable     (fifo_read_enable),
        .fifo_flush           (fifo_flush),
        .slot_free            (slot_free),
        .out_data             (out_data),
        .out_valid            (out_valid)
    );

endmodule

// File: tb/tb_clock_gen.sv
`timescale 1ns/100ps
// Testbench clock and reset generator
// 4 ns clock, rst_n held low for the first 3 cycles
module tb_clock_gen (
    output logic clock,
    output logic rst_n
);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;   // Release away from the active edge
    end

endmodule

// File: tb/tb_virtual_port_udp_rx.sv
`timescale 1ns/100ps
// Directed testbench for the UDP virtual port receive slot
// Builds Ethernet II / IPv4 / UDP frames with their FCS, sends them on the
// falling edge and checks the payload stream that comes back
module tb_virtual_port_udp_rx
    import udp_rx_pkg::*;
();

    typedef enum {
        NO_FRAME, GOOD_OWN, GOOD_BROADCAST,
        BAD_FCS, BAD_MAC, BAD_ETHERTYPE, BAD_PROTOCOL, BAD_PORT
    } frame_kind_t;

    logic         clock;
    logic         rst_n;
    mac_addr_t    mac_address;
    udp_port_t    udp_port;
    stream_word_t receive_data;
    logic         receive_data_enable;
    logic         out_enable;
    logic         receive_data_ready;
    stream_word_t out_data;
    logic         out_valid;

    logic [7:0]   frame[$];
    logic [7:0]   payload[$];
    stream_word_t received[$];     // Words seen by the monitor
    logic [31:0]  lfsr_state;
    string        test_name;
    int           test_errors;
    int           error_count;
    int           tests_passed;
    int           tests_failed;

    tb_clock_gen clock_gen (.clock(clock), .rst_n(rst_n));

    virtual_port_udp_rx uut (
        .clock               (clock),
        .rst_n               (rst_n),
        .mac_address         (mac_address),
        .udp_port            (udp_port),
        .receive_data        (receive_data),
        .receive_data_enable (receive_data_enable),
        .out_enable          (out_enable),
        .receive_data_ready  (receive_data_ready),
        .out_data            (out_data),
        .out_valid           (out_valid)
    );

    // Word is taken at the next rising edge
    always begin
        @(negedge clock);
        #1;
        if (rst_n && out_valid) begin
            received.push_back(out_data);
        end
    end

    ////////////////////////////////////////
    // Models
    ////////////////////////////////////////
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
    endfunction

    task automatic take_random(input int bits, output logic [7:0] value);
        value = 8'h00;
        for (int i = 0; i < bits; i++) begin
            value      = {value[6:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // Ethernet FCS, reflected, inverted at the end
    function automatic logic [31:0] frame_crc();
        logic [31:0] crc;
        crc = 32'hffffffff;
        foreach (frame[i]) begin
            crc = crc ^ {24'h0, frame[i]};
            repeat (8) begin
                crc = crc[0] ? ((crc >> 1) ^ 32'hedb88320) : (crc >> 1);
            end
        end
        return ~crc;
    endfunction

    task automatic push_word16(input logic [15:0] value);
        frame.push_back(value[15:8]);
        frame.push_back(value[7:0]);
    endtask

    task automatic make_payload(input int length);
        logic [7:0] value;
        payload.delete();
        for (int i = 0; i < length; i++) begin
            take_random(8, value);
            payload.push_back(value);
        end
    endtask

    task automatic build_frame(input frame_kind_t kind);
        mac_addr_t   dest;
        logic [15:0] ethertype;
        logic [7:0]  protocol;
        udp_port_t   port;
        logic [31:0] fcs;
        dest      = (kind == GOOD_BROADCAST) ? 48'hffffffffffff : mac_address;
        ethertype = 16'h0800;
        protocol  = 8'd17;
        port      = udp_port;
        case (kind)
            BAD_MAC:       dest      = mac_address ^ 48'h1;
            BAD_ETHERTYPE: ethertype = 16'h86dd;   // IPv6
            BAD_PROTOCOL:  protocol  = 8'd6;       // TCP
            BAD_PORT:      port      = udp_port + 16'd1;
            default:       ;
        endcase
        frame.delete();
        for (int i = 5; i >= 0; i--) begin
            frame.push_back(dest[8 * i +: 8]);
        end
        push_word16(16'h0200);   // Source MAC
        push_word16(16'h0000);
        push_word16(16'h0099);
        push_word16(ethertype);
        frame.push_back(8'h45);
        frame.push_back(8'h00);
        push_word16(16'(28 + payload.size()));
        push_word16(16'h1234);
        push_word16(16'h4000);
        frame.push_back(8'd64);
        frame.push_back(protocol);
        push_word16(16'h0000);   // Header checksum, not verified by the DUT
        push_word16(16'hc0a8);
        push_word16(16'h0001);
        push_word16(16'hc0a8);
        push_word16(16'h0002);
        push_word16(16'd5000);
        push_word16(port);
        push_word16(16'(8 + payload.size()));
        push_word16(16'h0000);
        foreach (payload[i]) begin
            frame.push_back(payload[i]);
        end
        while (frame.size() < 60) begin
            frame.push_back(8'h00);   // Pad to minimum size
        end
        fcs = frame_crc();
        if (kind == BAD_FCS) begin
            fcs = fcs ^ 32'h00000100;
        end
        for (int i = 0; i < 4; i++) begin
            frame.push_back(fcs[8 * i +: 8]);
        end
    endtask

    ////////////////////////////////////////
    // Checks and reporting
    ////////////////////////////////////////
    task automatic note_error();
        test_errors++;
        error_count++;
    endtask

    task automatic check_word(input string what, input stream_word_t expected,
                              input stream_word_t actual);
        if (actual !== expected) begin
            $display("ERR %s %s: expected last=%0b data=%02h actual last=%0b data=%02h",
                     test_name, what, expected.last, expected.data, actual.last, actual.data);
            note_error();
        end
    endtask

    task automatic check_bit(input string what, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERR %s %s: expected %0b actual %0b", test_name, what, expected, actual);
            note_error();
        end
    endtask

    task automatic check_count(input string what, input int expected, input int actual);
        if (actual != expected) begin
            $display("ERR %s %s: expected %0d actual %0d", test_name, what, expected, actual);
            note_error();
        end
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = 0;
        received.delete();
    endtask

    task automatic finish_test();
        if (test_errors == 0) begin
            tests_passed++;
            $display("%s: ok", test_name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", test_name, test_errors);
        end
    endtask

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////
    task automatic send_frame();
        int cycles;
        cycles = 0;
        @(negedge clock);
        while (!receive_data_ready && cycles <= 2000) begin
            cycles++;
            @(negedge clock);
        end
        if (!receive_data_ready) begin
            $display("%s: receive_data_ready never came high, frame not sent", test_name);
            note_error();
        end else begin
            for (int i = 0; i < frame.size(); i++) begin
                if (i > 0) begin
                    @(negedge clock);
                end
                receive_data.last   = (i == frame.size() - 1);
                receive_data.data   = frame[i];
                receive_data_enable = 1'b1;
            end
            @(negedge clock);
            receive_data_enable = 1'b0;
            receive_data        = '0;
        end
    endtask

    task automatic collect_words(input int count, input bit random_enable);
        int         cycles;
        logic [7:0] bit_taken;
        cycles = 0;
        while (received.size() < count && cycles <= 5000) begin
            @(negedge clock);
            if (random_enable) begin
                take_random(1, bit_taken);
                out_enable = bit_taken[0];
            end
            cycles++;
        end
        if (received.size() < count) begin
            $display("%s: output stream stopped after %0d of %0d words",
                     test_name, received.size(), count);
            note_error();
        end
        @(negedge clock);
        out_enable = 1'b1;
        repeat (16) @(negedge clock);   // Window for stray words
    endtask

    ////////////////////////////////////////
    // Tests
    ////////////////////////////////////////
    task automatic test_reset_state();
        begin_test("reset_state");
        @(negedge clock);
        check_bit("out_valid", 1'b0, out_valid);
        check_bit("receive_data_ready", 1'b1, receive_data_ready);
        finish_test();
    endtask

    // Optional dropped frame, then a good frame whose payload alone must appear
    task automatic run_frame_test(input string name, input frame_kind_t first_kind,
                                  input frame_kind_t good_kind, input int length,
                                  input bit random_enable);
        stream_word_t expected[$];
        stream_word_t word;
        begin_test(name);
        if (first_kind != NO_FRAME) begin
            make_payload(24);
            build_frame(first_kind);
            send_frame();
        end
        make_payload(length);
        foreach (payload[i]) begin
            word.last = (i == payload.size() - 1);
            word.data = payload[i];
            expected.push_back(word);
        end
        build_frame(good_kind);
        send_frame();
        collect_words(expected.size(), random_enable);
        check_count("word count", expected.size(), received.size());
        for (int i = 0; i < expected.size() && i < received.size(); i++) begin
            check_word($sformatf("word %0d", i), expected[i], received[i]);
        end
        finish_test();
    endtask

    initial begin
        int cycles;
        mac_address         = 48'h02005e102030;
        udp_port            = 16'd4660;
        receive_data        = '0;
        receive_data_enable = 1'b0;
        out_enable          = 1'b1;
        lfsr_state          = 32'h9c4ed1fb;
        test_name           = "reset";
        test_errors         = 0;
        error_count         = 0;
        tests_passed        = 0;
        tests_failed        = 0;

        cycles = 0;
        while (rst_n !== 1'b1 && cycles <= 20) begin
            @(negedge clock);
            cycles++;
        end
        if (rst_n !== 1'b1) begin
            $display("Reset was never released");
            error_count++;
        end

        test_reset_state();
        run_frame_test("good_frame", NO_FRAME, GOOD_OWN, 46, 1'b0);
        run_frame_test("broadcast_frame", NO_FRAME, GOOD_BROADCAST, 20, 1'b0);
        run_frame_test("bad_fcs", BAD_FCS, GOOD_OWN, 17, 1'b0);
        run_frame_test("wrong_mac", BAD_MAC, GOOD_OWN, 12, 1'b0);
        run_frame_test("wrong_ethertype", BAD_ETHERTYPE, GOOD_OWN, 12, 1'b0);
        run_frame_test("wrong_protocol", BAD_PROTOCOL, GOOD_OWN, 12, 1'b0);
        run_frame_test("wrong_port", BAD_PORT, GOOD_OWN, 12, 1'b0);
        run_frame_test("min_frame_padding", NO_FRAME, GOOD_OWN, 5, 1'b0);
        run_frame_test("backpressure", NO_FRAME, GOOD_OWN, 200, 1'b1);

        $display("Tests passed %0d, failed %0d, errors %0d",
                 tests_passed, tests_failed, error_count);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: tb.f
rtl/udp_rx_pkg.sv
rtl/frame_check_sequence_checker.sv
rtl/ethernet_frame_parser.sv
rtl/payload_fifo.sv
rtl/udp_receive_handler.sv
rtl/virtual_port_udp_rx.sv
tb/tb_clock_gen.sv
tb/tb_virtual_port_udp_rx.sv
